//--- Bender.yml
package:
  name: util_adcfifo

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - adcfifo_pkg.sv
      - adcfifo_wr_if.sv
      - adcfifo_capture.sv
      - adcfifo_drain.sv
      - adcfifo_mem_asym.sv
      - util_adcfifo.sv
  - target: test
    include_dirs:
      - .
    files:
      - adcfifo_asserts.sv
      - tb_adcfifo.sv

//--- adcfifo_asserts.sv
`include "adcfifo_params.svh"

module adcfifo_asserts import adcfifo_pkg::*; #(
  parameter bit DRAIN = 1'b0
) (
  input logic                               clk,
  input logic                               rst,
  input capture_state_t                     state,
  input logic                               wr_en,
  input logic [`ADCFIFO_ADC_ADDR_WIDTH-1:0] waddr,
  input logic                               rel_toggle,
  input logic                               valid,
  input logic                               ready,
  input logic [`ADCFIFO_DMA_DATA_WIDTH-1:0] data
);

  int fail_count = 0;

  if (DRAIN) begin : g_drain
    // a stalled lane keeps its value
    stall_holds: assert property (@(posedge clk) disable iff (rst)
      (valid && !ready) |=> (valid && $stable(data)))
      else begin
        fail_count++;
        $error("dma_valid or dma_data moved while stalled");
      end

    no_valid_without_req: assert property (@(posedge clk) rst |=> !valid)
      else begin
        fail_count++;
        $error("dma_valid high without a request");
      end
  end else begin : g_capture
    // idle parks the toggle low, every other flip needs a group end
    toggle_on_group_end: assert property (@(posedge clk) disable iff (rst)
      ($changed(rel_toggle) && ($past(state) != CAP_IDLE)) |->
        (wr_en && (((waddr % `ADCFIFO_RELEASE_WORDS) == `ADCFIFO_RELEASE_WORDS - 1) ||
                   (&waddr))))
      else begin
        fail_count++;
        $error("rel_toggle flipped without a group end write");
      end

    no_write_in_full: assert property (@(posedge clk) disable iff (rst)
      (state == CAP_FULL) |=> !wr_en)
      else begin
        fail_count++;
        $error("write strobe while capture is full");
      end
  end

endmodule

bind adcfifo_capture adcfifo_asserts #(.DRAIN(1'b0)) cap_checks (
  .clk        (adc_clk),
  .rst        (adc_rst),
  .state      (state),
  .wr_en      (wr.wr),
  .waddr      (wr.waddr),
  .rel_toggle (wr.rel_toggle),
  .valid      (1'b0),
  .ready      (1'b0),
  .data       ('0)
);

bind adcfifo_drain adcfifo_asserts #(.DRAIN(1'b1)) drain_checks (
  .clk        (dma_clk),
  .rst        (dma_rst),
  .state      (adcfifo_pkg::CAP_IDLE),
  .wr_en      (1'b0),
  .waddr      ('0),
  .rel_toggle (1'b0),
  .valid      (dma_valid),
  .ready      (dma_ready),
  .data       (dma_data)
);

//--- adcfifo_capture.sv
`include "adcfifo_params.svh"

module adcfifo_capture import adcfifo_pkg::*; (
  input  logic                               adc_clk,
  input  logic                               adc_rst,
  input  logic                               adc_wr,
  input  logic [`ADCFIFO_ADC_DATA_WIDTH-1:0] adc_wdata,
  input  logic                               dma_xfer_req,
  adcfifo_wr_if.writer                       wr
);

  localparam logic [`ADCFIFO_ADC_ADDR_WIDTH-1:0] LAST_ADDR = '1;
  localparam int REL_BITS = $clog2(`ADCFIFO_RELEASE_WORDS);

  capture_state_t                     state;
  logic [2:0]                         req_sync;
  logic                               req_on;
  logic                               req_rise;
  logic                               accept;
  logic                               rel_now;
  logic [`ADCFIFO_ADC_ADDR_WIDTH-1:0] next_addr;

  assign req_on   = req_sync[2];
  assign req_rise = req_sync[1] & ~req_sync[2];
  assign accept   = adc_wr && (state == CAP_FILL) && req_on;

  // end of a release group, or the very last word
  assign rel_now = accept &&
                   ((&next_addr[REL_BITS-1:0]) || (next_addr == LAST_ADDR));

  // *********************************************************************
  // request sync and capture fsm
  // *********************************************************************

  always_ff @(posedge adc_clk or posedge adc_rst) begin
    if (adc_rst) begin
      req_sync <= '0;
      state    <= CAP_IDLE;
    end else begin
      req_sync <= {req_sync[1:0], dma_xfer_req};
      case (state)
        CAP_IDLE: begin
          if (req_rise) begin
            state <= CAP_ARM;
          end
        end
        CAP_ARM: begin
          state <= req_on ? CAP_FILL : CAP_IDLE;
        end
        CAP_FILL: begin
          if (!req_on) begin
            state <= CAP_IDLE;
          end else if (accept && (next_addr == LAST_ADDR)) begin
            state <= CAP_FULL;
          end
        end
        default: begin
          if (!req_on) begin
            state <= CAP_IDLE;
          end
        end
      endcase
    end
  end

  // *********************************************************************
  // write port and release publisher
  // *********************************************************************

  always_ff @(posedge adc_clk or posedge adc_rst) begin
    if (adc_rst) begin
      wr.wr         <= 1'b0;
      wr.waddr      <= '0;
      next_addr     <= '0;
      wr.rel_toggle <= 1'b0;
      wr.rel_addr   <= '0;
    end else begin
      wr.wr <= accept;
      if ((state == CAP_IDLE) || (state == CAP_ARM)) begin
        next_addr <= '0;
      end else if (accept) begin
        wr.waddr  <= next_addr;
        next_addr <= next_addr + 1'b1;
      end
      // toggle parks low between captures, so a new request
      // never sees a stale edge from the previous one
      if (state == CAP_IDLE) begin
        wr.rel_toggle <= 1'b0;
        wr.rel_addr   <= '0;
      end else if (rel_now) begin
        wr.rel_toggle <= ~wr.rel_toggle;
        wr.rel_addr   <= next_addr;
      end
    end
  end

  // data rides alongside the strobe
  always_ff @(posedge adc_clk) begin
    wr.wdata <= adc_wdata;
  end

endmodule

//--- adcfifo_drain.sv
`include "adcfifo_params.svh"

module adcfifo_drain import adcfifo_pkg::*; (
  input  logic                               dma_clk,
  input  logic                               dma_xfer_req,
  input  logic                               dma_ready,
  input  logic [`ADCFIFO_DMA_DATA_WIDTH-1:0] rdata,
  adcfifo_wr_if.reader                       rel,
  output logic [`ADCFIFO_DMA_ADDR_WIDTH-1:0] raddr,
  output logic                               dma_valid,
  output logic [`ADCFIFO_DMA_DATA_WIDTH-1:0] dma_data
);

  localparam logic [`ADCFIFO_DMA_ADDR_WIDTH-1:0] LAST_LANE = '1;

  logic                               dma_rst;
  logic [2:0]                         rel_sync;
  logic                               rel_edge;
  logic [`ADCFIFO_ADC_ADDR_WIDTH:0]   rel_words;
  logic [`ADCFIFO_DMA_ADDR_WIDTH:0]   lane_limit;
  logic                               rd_done;
  logic                               readable;
  logic                               rd;
  logic                               rd_d;
  logic                               ready_s;
  logic                               pop;
  logic                               load_out;
  logic [1:0]                         used;
  logic                               room;
  logic                               skid_valid;
  logic [`ADCFIFO_DMA_DATA_WIDTH-1:0] skid_data;

  // the whole read side restarts whenever the request is low
  assign dma_rst = ~dma_xfer_req;

  // *********************************************************************
  // release sync and lane limit
  // *********************************************************************

  assign rel_edge  = rel_sync[2] ^ rel_sync[1];
  assign rel_words = {1'b0, rel.rel_addr} + 1'b1;

  always_ff @(posedge dma_clk) begin
    if (dma_rst) begin
      rel_sync   <= '0;
      lane_limit <= '0;
    end else begin
      rel_sync <= {rel_sync[1:0], rel.rel_toggle};
      // rel_addr is stable here, the toggle came after it
      if (rel_edge) begin
        lane_limit <= {rel_words, lane_index_t'(0)};
      end
    end
  end

  // *********************************************************************
  // read issue
  // *********************************************************************

  assign ready_s  = (`ADCFIFO_READY_ENABLE != 0) ? dma_ready : 1'b1;
  assign pop      = dma_valid && ready_s;
  assign load_out = !dma_valid || pop;

  // skid entries in use plus the read still inside the memory
  assign used     = {1'b0, dma_valid} + {1'b0, skid_valid} + {1'b0, rd_d};
  assign room     = (used < 2'd2) || pop;
  assign readable = !rd_done && ({1'b0, raddr} < lane_limit);
  assign rd       = readable && room;

  always_ff @(posedge dma_clk) begin
    if (dma_rst) begin
      raddr   <= '0;
      rd_done <= 1'b0;
      rd_d    <= 1'b0;
    end else begin
      rd_d <= rd;
      if (rd) begin
        if (raddr == LAST_LANE) begin
          rd_done <= 1'b1;
        end else begin
          raddr <= raddr + 1'b1;
        end
      end
    end
  end

  // *********************************************************************
  // two-entry skid register
  // *********************************************************************

  always_ff @(posedge dma_clk) begin
    if (dma_rst) begin
      dma_valid  <= 1'b0;
      skid_valid <= 1'b0;
    end else if (load_out) begin
      if (skid_valid) begin
        dma_valid  <= 1'b1;
        skid_valid <= rd_d;
      end else begin
        dma_valid <= rd_d;
      end
    end else if (rd_d) begin
      skid_valid <= 1'b1;
    end
  end

  always_ff @(posedge dma_clk) begin
    if (load_out) begin
      if (skid_valid) begin
        dma_data  <= skid_data;
        skid_data <= rdata;
      end else begin
        dma_data <= rdata;
      end
    end else if (rd_d) begin
      skid_data <= rdata;
    end
  end

endmodule

//--- adcfifo_mem_asym.sv
`include "adcfifo_params.svh"

module adcfifo_mem_asym (
  input  logic                               adc_clk,
  adcfifo_wr_if.mem                          wr,
  input  logic                               dma_clk,
  input  logic [`ADCFIFO_DMA_ADDR_WIDTH-1:0] raddr,
  output logic [`ADCFIFO_DMA_DATA_WIDTH-1:0] rdata
);

  localparam int DEPTH     = 2 ** `ADCFIFO_ADC_ADDR_WIDTH;
  localparam int LANE_BITS = $clog2(`ADCFIFO_RATIO);

  logic [`ADCFIFO_ADC_DATA_WIDTH-1:0] mem [0:DEPTH-1];
  logic [`ADCFIFO_ADC_ADDR_WIDTH-1:0] word_addr;
  logic [LANE_BITS-1:0]               lane_sel;
  logic [`ADCFIFO_ADC_DATA_WIDTH-1:0] rd_word;

  // *********************************************************************
  // wide write port, adc side
  // *********************************************************************

  always_ff @(posedge adc_clk) begin
    if (wr.wr) begin
      mem[wr.waddr] <= wr.wdata;
    end
  end

  // *********************************************************************
  // narrow read port, dma side
  // *********************************************************************

  // upper lane bits pick the word, lower bits the lane
  assign word_addr = raddr[`ADCFIFO_DMA_ADDR_WIDTH-1:LANE_BITS];
  assign lane_sel  = raddr[LANE_BITS-1:0];
  assign rd_word   = mem[word_addr];

  // lane 0 sits in the low bits of the word
  always_ff @(posedge dma_clk) begin
    rdata <= rd_word[lane_sel*`ADCFIFO_DMA_DATA_WIDTH +: `ADCFIFO_DMA_DATA_WIDTH];
  end

endmodule

//--- adcfifo_params.svh
`ifndef ADCFIFO_PARAMS_SVH
`define ADCFIFO_PARAMS_SVH

// *********************************************************************
// data widths
// *********************************************************************

// one captured adc word
`define ADCFIFO_ADC_DATA_WIDTH 64

// one output lane on the dma side
`define ADCFIFO_DMA_DATA_WIDTH 16

// lanes per captured word, power of two
`define ADCFIFO_RATIO 4

// *********************************************************************
// depths and release
// *********************************************************************

// 64 words on the write port
`define ADCFIFO_ADC_ADDR_WIDTH 6

// 256 lanes on the read port
`define ADCFIFO_DMA_ADDR_WIDTH 8

// words per release group, power of two
`define ADCFIFO_RELEASE_WORDS 8

// 0 for a sink without back-pressure
`define ADCFIFO_READY_ENABLE 1

`endif

//--- adcfifo_pkg.sv
`include "adcfifo_params.svh"

package adcfifo_pkg;

  // capture progress on the adc side
  //   idle  waiting for a new request
  //   arm   one cycle to restart the write address
  //   fill  accepting words
  //   full  buffer complete, writes stopped
  typedef enum logic [1:0] {
    CAP_IDLE,
    CAP_ARM,
    CAP_FILL,
    CAP_FULL
  } capture_state_t;

  // lane position inside one captured word
  typedef logic [$clog2(`ADCFIFO_RATIO)-1:0] lane_index_t;

endpackage

//--- adcfifo_wr_if.sv
`include "adcfifo_params.svh"

interface adcfifo_wr_if;

  // memory write port, adc clock domain
  logic                               wr;
  logic [`ADCFIFO_ADC_ADDR_WIDTH-1:0] waddr;
  logic [`ADCFIFO_ADC_DATA_WIDTH-1:0] wdata;

  // release info, held stable while it crosses to the dma side
  logic                               rel_toggle;
  logic [`ADCFIFO_ADC_ADDR_WIDTH-1:0] rel_addr;

  modport writer (
    output wr,
    output waddr,
    output wdata,
    output rel_toggle,
    output rel_addr
  );

  modport mem (
    input wr,
    input waddr,
    input wdata
  );

  modport reader (
    input rel_toggle,
    input rel_addr
  );

endinterface

//--- list.f
+incdir+.
adcfifo_pkg.sv
adcfifo_wr_if.sv
adcfifo_capture.sv
adcfifo_drain.sv
adcfifo_mem_asym.sv
util_adcfifo.sv
adcfifo_asserts.sv
tb_adcfifo.sv

//--- tb_adcfifo.sv
`include "adcfifo_params.svh"

module tb_adcfifo import adcfifo_pkg::*; ();

  localparam int WORDS      = 2 ** `ADCFIFO_ADC_ADDR_WIDTH;
  localparam int LANES      = 2 ** `ADCFIFO_DMA_ADDR_WIDTH;
  localparam int DW         = `ADCFIFO_DMA_DATA_WIDTH;
  localparam int NUM_ROWS   = 6;
  localparam int WAIT_LIMIT = 5000;

  logic                               adc_clk;
  logic                               adc_rst;
  logic                               adc_wr;
  logic [`ADCFIFO_ADC_DATA_WIDTH-1:0] adc_wdata;
  logic                               dma_clk;
  logic                               dma_xfer_req;
  logic                               dma_ready;
  logic                               dma_valid;
  logic [DW-1:0]                      dma_data;

  // words before a pause, write duty %, ready duty %, drop after word (-1 none)
  int scen [0:NUM_ROWS-1][0:3] = '{
    '{64, 100, 100, -1},
    '{64,  40, 100, -1},
    '{64, 100,  35, -1},
    '{44,  70,  60, -1},
    '{64,  80,  70, 29},
    '{64,  60,  80, -1}
  };

  // accepted words of the current capture, in write order
  logic [`ADCFIFO_ADC_DATA_WIDTH-1:0] words_q [$];
  int                                 lane_cnt;
  int                                 released;
  int                                 rdy_duty;
  int                                 errors;
  int                                 timeouts;

  initial begin
    adc_clk = 1'b0;
    forever #20 adc_clk = ~adc_clk;
  end

  initial begin
    dma_clk = 1'b0;
    forever #14 dma_clk = ~dma_clk;
  end

  util_adcfifo UUT (
    .adc_clk      (adc_clk),
    .adc_rst      (adc_rst),
    .adc_wr       (adc_wr),
    .adc_wdata    (adc_wdata),
    .dma_clk      (dma_clk),
    .dma_xfer_req (dma_xfer_req),
    .dma_ready    (dma_ready),
    .dma_valid    (dma_valid),
    .dma_data     (dma_data)
  );

  // lane idx of the recorded words, lowest lane first
  function automatic logic [DW-1:0] expected_lane(input int idx);
    logic [`ADCFIFO_ADC_DATA_WIDTH-1:0] word;
    lane_index_t                        lane;
    word = words_q[idx / `ADCFIFO_RATIO];
    lane = lane_index_t'(idx % `ADCFIFO_RATIO);
    return word[lane * DW +: DW];
  endfunction

  // *********************************************************************
  // dma sink, ready and sampling on the falling edge
  // *********************************************************************

  always @(negedge dma_clk) begin
    dma_ready = ($urandom_range(99) < rdy_duty);
    if (dma_xfer_req && dma_valid && dma_ready) begin
      if (lane_cnt < released) begin
        assert (dma_data === expected_lane(lane_cnt)) else begin
          errors++;
          $display("** Error at %0t: dma_data lane %0d is %h, expected %h",
                   $time, lane_cnt, dma_data, expected_lane(lane_cnt));
        end
      end else begin
        errors++;
        $display("lane %0d came out before its group was released", lane_cnt);
      end
      lane_cnt++;
    end
  end

  // adc driver, records each word it offers while capture is filling
  task automatic write_words(input int target, input int duty);
    int cycles;
    cycles = 0;
    while ((words_q.size() < target) && (cycles < WAIT_LIMIT)) begin
      @(negedge adc_clk);
      cycles++;
      if ($urandom_range(99) < duty) begin
        adc_wr    = 1'b1;
        adc_wdata = {$urandom, $urandom};
        words_q.push_back(adc_wdata);
        if (((words_q.size() % `ADCFIFO_RELEASE_WORDS) == 0) || (words_q.size() == WORDS)) begin
          released = words_q.size() * `ADCFIFO_RATIO;
        end
      end else begin
        adc_wr = 1'b0;
      end
    end
    @(negedge adc_clk);
    adc_wr = 1'b0;
    assert (words_q.size() == target) else begin
      timeouts++;
      $display("timed out writing words, %0d of %0d written", words_q.size(), target);
    end
  endtask

  task automatic wait_lanes(input int target);
    int cycles;
    cycles = 0;
    while ((lane_cnt < target) && (cycles < WAIT_LIMIT)) begin
      @(posedge dma_clk);
      cycles++;
    end
    assert (lane_cnt >= target) else begin
      timeouts++;
      $display("timed out waiting for %0d lanes, only %0d arrived", target, lane_cnt);
    end
  endtask

  // no further lanes may show up once target is reached
  task automatic check_quiet(input int target);
    repeat (60) @(posedge dma_clk);
    assert (lane_cnt == target) else begin
      errors++;
      $display("expected %0d lanes in total, got %0d", target, lane_cnt);
    end
  endtask

  task automatic wait_valid_low();
    int cycles;
    cycles = 0;
    while ((dma_valid !== 1'b0) && (cycles < 100)) begin
      @(negedge dma_clk);
      cycles++;
    end
    assert (dma_valid === 1'b0) else begin
      errors++;
      $display("dma_valid stayed high after the request dropped");
    end
  endtask

  task automatic run_row(input int row);
    int words;
    int duty;
    int drop_at;
    words    = scen[row][0];
    duty     = scen[row][1];
    drop_at  = scen[row][3];
    words_q.delete();
    lane_cnt = 0;
    released = 0;
    rdy_duty = scen[row][2];
    @(negedge adc_clk);
    dma_xfer_req = 1'b1;
    // request sync and arm take 3 to 4 cycles
    repeat (8) @(negedge adc_clk);
    if (drop_at >= 0) begin
      write_words(drop_at, duty);
    end else begin
      write_words(words, duty);
      if (words < WORDS) begin
        // partial group stays hidden until the buffer fills
        wait_lanes(released);
        check_quiet(released);
        write_words(WORDS, duty);
      end
      wait_lanes(LANES);
      check_quiet(LANES);
    end
    @(negedge adc_clk);
    dma_xfer_req = 1'b0;
    wait_valid_low();
    repeat (10) @(negedge adc_clk);
  endtask

  task automatic finish_run();
    int assert_fails;
    assert_fails = UUT.i_capture.cap_checks.fail_count +
                   UUT.i_drain.drain_checks.fail_count;
    $display("errors: %0d  assertion failures: %0d  timeouts: %0d",
             errors, assert_fails, timeouts);
    if ((errors == 0) && (assert_fails == 0) && (timeouts == 0)) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  endtask

  // *********************************************************************
  // main sequence
  // *********************************************************************

  initial begin
    void'($urandom(32'h2b9a_dc85));
    adc_rst      = 1'b1;
    adc_wr       = 1'b0;
    adc_wdata    = '0;
    dma_xfer_req = 1'b0;
    dma_ready    = 1'b0;
    rdy_duty     = 0;
    lane_cnt     = 0;
    released     = 0;
    errors       = 0;
    timeouts     = 0;
    repeat (10) @(negedge adc_clk);
    adc_rst = 1'b0;
    repeat (5) @(negedge adc_clk);
    for (int row = 0; row < NUM_ROWS; row++) begin
      run_row(row);
    end
    finish_run();
  end

endmodule

//--- util_adcfifo.sv
`include "adcfifo_params.svh"

module util_adcfifo (
  // adc side
  input  logic                               adc_clk,
  input  logic                               adc_rst,
  input  logic                               adc_wr,
  input  logic [`ADCFIFO_ADC_DATA_WIDTH-1:0] adc_wdata,

  // dma side
  input  logic                               dma_clk,
  input  logic                               dma_xfer_req,
  input  logic                               dma_ready,
  output logic                               dma_valid,
  output logic [`ADCFIFO_DMA_DATA_WIDTH-1:0] dma_data
);

  logic [`ADCFIFO_DMA_ADDR_WIDTH-1:0] dma_raddr;
  logic [`ADCFIFO_DMA_DATA_WIDTH-1:0] dma_rdata;

  // write port and release info from the capture side
  adcfifo_wr_if wr_bus ();

  adcfifo_capture i_capture (
    .adc_clk      (adc_clk),
    .adc_rst      (adc_rst),
    .adc_wr       (adc_wr),
    .adc_wdata    (adc_wdata),
    .dma_xfer_req (dma_xfer_req),
    .wr           (wr_bus.writer)
  );

  adcfifo_mem_asym i_mem_asym (
    .adc_clk (adc_clk),
    .wr      (wr_bus.mem),
    .dma_clk (dma_clk),
    .raddr   (dma_raddr),
    .rdata   (dma_rdata)
  );

  adcfifo_drain i_drain (
    .dma_clk      (dma_clk),
    .dma_xfer_req (dma_xfer_req),
    .dma_ready    (dma_ready),
    .rdata        (dma_rdata),
    .rel          (wr_bus.reader),
    .raddr        (dma_raddr),
    .dma_valid    (dma_valid),
    .dma_data     (dma_data)
  );

endmodule
